// ==== design/csr_file.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "priv_cfg.svh"

module csr_file (
    input  wire logic  clk,
    input  wire logic  rstn,
    csr_if.file        csr,
    output logic [1:0] plv,
    output logic       ie
);
    import priv_pkg::*;

    localparam csr_num_t SAVE_BASE = `CSR_SAVE0;

    word_t    crmd;           // plv 1:0, ie 2, da 3
    word_t    prmd;           // pplv 1:0, pie 2
    word_t    era;
    word_t    save_q [0:3];
    word_t    rd_val;
    logic     is_save;
    logic [1:0] save_idx;
    logic     wen_crmd;
    logic     wen_prmd;
    logic     wen_era;
    logic     wen_save;

    assign is_save  = csr.addr[`PRIV_CSR_NUM_W-1:2] == SAVE_BASE[`PRIV_CSR_NUM_W-1:2];
    assign save_idx = csr.addr[1:0];

    assign wen_crmd = csr.wen & (csr.addr == `CSR_CRMD);
    assign wen_prmd = csr.wen & (csr.addr == `CSR_PRMD);
    assign wen_era  = csr.wen & (csr.addr == `CSR_ERA);
    assign wen_save = csr.wen & is_save;

    always_comb
    begin
        rd_val = '0;  // unmodeled numbers read zero
        case (csr.addr)
            `CSR_CRMD: rd_val = crmd;
            `CSR_PRMD: rd_val = prmd;
            `CSR_ERA:  rd_val = era;
            default:
            begin
                if (is_save)
                    rd_val = save_q[save_idx];
            end
        endcase
    end

    assign csr.rdata    = csr.ren ? rd_val : '0;
    assign csr.ertn_era = era;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            crmd <= `CRMD_RESET;
            prmd <= '0;
            era  <= '0;
        end
        else
        begin
            if (csr.ertn)
                crmd[2:0] <= prmd[2:0];  // plv <- pplv, ie <- pie
            else if (wen_crmd)
                crmd <= csr.wdata & `CRMD_WMASK;
            if (wen_prmd)
                prmd <= csr.wdata & `PRMD_WMASK;
            if (wen_era)
                era <= csr.wdata;
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < 4; i++)
                save_q[i] <= '0;
        end
        else if (wen_save)
        begin
            save_q[save_idx] <= csr.wdata;
        end
    end

    assign plv = crmd[1:0];
    assign ie  = crmd[2];

endmodule

`default_nettype wire

// ==== design/csr_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface csr_if;
    import priv_pkg::*;

    csr_num_t addr;
    word_t    wdata;
    logic     wen;
    logic     ren;
    word_t    rdata;     // combinational read
    word_t    ertn_era;  // current ERA for the return address
    logic     ertn;      // restore strobe

    modport exec (
        output addr, wdata, wen, ren, ertn,
        input  rdata, ertn_era
    );

    modport file (
        input  addr, wdata, wen, ren, ertn,
        output rdata, ertn_era
    );

endinterface

`default_nettype wire

// ==== design/priv_cfg.svh ====
`ifndef PRIV_CFG_SVH
`define PRIV_CFG_SVH

// datapath and CSR number widths
`define PRIV_XLEN       32
`define PRIV_CSR_NUM_W  14

// one-hot instruction class vector
`define PRIV_CLASS_W    3
`define PRIV_CLS_CSR    0
`define PRIV_CLS_CACHE  1
`define PRIV_CLS_ERTN   2

// modeled CSR numbers, SAVE0..SAVE3 are consecutive
`define CSR_CRMD        14'h0
`define CSR_PRMD        14'h1
`define CSR_ERA         14'h6
`define CSR_SAVE0       14'h30

`define CRMD_RESET      32'h0000_0008
`define CRMD_WMASK      32'h0000_000f
`define PRMD_WMASK      32'h0000_0007

`endif

// ==== design/priv_exec.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "priv_cfg.svh"

module priv_exec (
    input  wire logic                  clk,
    input  wire logic                  rstn,
    input  wire logic                  en,
    input  wire priv_pkg::word_t       ins,
    input  wire priv_pkg::word_t       rd_data,
    input  wire priv_pkg::word_t       rj_data,
    input  wire priv_pkg::priv_class_t pr_type,
    input  wire logic                  cacop_i_ready,
    input  wire logic                  cacop_d_ready,
    input  wire logic                  cacop_i_done,
    input  wire logic                  cacop_d_done,
    output logic                       done,
    output priv_pkg::word_t            rd_result,
    output priv_pkg::word_t            cacop_vaddr,
    output priv_pkg::cacop_code_t      cacop_code,
    output logic                       cacop_i_req,
    output logic                       cacop_d_req,
    output logic                       ertn_en,
    csr_if.exec                        csr
);
    import priv_pkg::*;

    csr_num_t    csr_num;
    rj_t         rj;
    imm12_t      imm;
    word_t       imm_ext;
    logic        is_xchg;
    logic        cls_csr;
    logic        cls_cache;
    logic        cls_ertn;
    logic        to_icache;
    logic        to_dcache;
    logic        start_csr;
    logic        start_ci;
    logic        start_cd;
    logic        start_nop;
    logic        start_ertn;
    priv_state_t state;
    priv_state_t next_state;

    // instruction fields
    assign csr_num = ins[23:10];
    assign rj      = ins[9:5];
    assign imm     = ins[21:10];
    assign is_xchg = |rj[4:1];  // rj >= 2 selects csrxchg

    assign cls_csr   = pr_type[`PRIV_CLS_CSR];
    assign cls_cache = pr_type[`PRIV_CLS_CACHE];
    assign cls_ertn  = pr_type[`PRIV_CLS_ERTN];
    assign to_icache = cls_cache & (ins[2:0] == 3'd0);
    assign to_dcache = cls_cache & (ins[2:0] == 3'd1);

    // accepted only while idle, csr wins over cache over ertn
    assign start_csr  = (state == IDLE) & en & cls_csr;
    assign start_ci   = (state == IDLE) & en & !cls_csr & to_icache;
    assign start_cd   = (state == IDLE) & en & !cls_csr & to_dcache;
    assign start_nop  = (state == IDLE) & en & !cls_csr & cls_cache & !to_icache & !to_dcache;
    assign start_ertn = (state == IDLE) & en & !cls_csr & !cls_cache & cls_ertn;

    // cacop target address
    assign imm_ext     = {{(`PRIV_XLEN-12){imm[11]}}, imm};
    assign cacop_vaddr = rj_data + imm_ext;
    assign cacop_code  = ins[4:3];

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (start_csr | start_nop)
                    next_state = CSR;
                else if (start_ci)
                    next_state = CI_CALL;
                else if (start_cd)
                    next_state = CD_CALL;
                else if (start_ertn)
                    next_state = ERTN;
            end
            CI_CALL:
            begin
                if (cacop_i_ready)
                    next_state = cacop_i_done ? IDLE : CI_WAIT;
            end
            CI_WAIT:
            begin
                if (cacop_i_done)
                    next_state = IDLE;
            end
            CD_CALL:
            begin
                if (cacop_d_ready)
                    next_state = cacop_d_done ? IDLE : CD_WAIT;
            end
            CD_WAIT:
            begin
                if (cacop_d_done)
                    next_state = IDLE;
            end
            CSR,
            ERTN:
            begin
                next_state = IDLE;
            end
            default:
            begin
                next_state = IDLE;
            end
        endcase
    end

    // old csr value, read in the accept cycle
    always_ff @(posedge clk)
    begin
        if (start_csr)
            rd_result <= csr.rdata;
    end

    // csr access
    assign csr.addr  = csr_num;
    assign csr.ren   = start_csr;
    assign csr.wen   = (state == CSR) & cls_csr & (rj != '0);  // rj 0 is csrrd
    assign csr.wdata = is_xchg ? ((rd_result & ~rj_data) | (rd_data & rj_data)) : rd_data;
    assign csr.ertn  = (state == ERTN);

    assign ertn_en = (state == ERTN);

    always_comb
    begin
        done = 1'b0;
        case (state)
            CSR,
            ERTN:    done = 1'b1;
            CI_CALL: done = cacop_i_ready & cacop_i_done;  // done may come with ready
            CI_WAIT: done = cacop_i_done;
            CD_CALL: done = cacop_d_ready & cacop_d_done;
            CD_WAIT: done = cacop_d_done;
            default: done = 1'b0;
        endcase
    end

    // request held until ready is seen, low the cycle after
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            cacop_i_req <= 1'b0;
            cacop_d_req <= 1'b0;
        end
        else
        begin
            cacop_i_req <= start_ci | ((state == CI_CALL) & !cacop_i_ready);
            cacop_d_req <= start_cd | ((state == CD_CALL) & !cacop_d_ready);
        end
    end

endmodule

`default_nettype wire

// ==== design/priv_pkg.sv ====
`default_nettype none

package priv_pkg;

`include "priv_cfg.svh"

    // architectural data word
    typedef logic [`PRIV_XLEN-1:0] word_t;

    // CSR number field of csr instructions
    typedef logic [`PRIV_CSR_NUM_W-1:0] csr_num_t;

    // one-hot class from the issue stage
    typedef logic [`PRIV_CLASS_W-1:0] priv_class_t;

    // cacop operation, ins[4:3]
    typedef logic [1:0] cacop_code_t;

    // general register index field
    typedef logic [4:0] rj_t;

    // cacop address offset field
    typedef logic [11:0] imm12_t;

    typedef enum logic [2:0] {
        IDLE,
        CSR,        // csr write cycle, also ends a cacop no-op
        CI_CALL,
        CI_WAIT,
        CD_CALL,
        CD_WAIT,
        ERTN
    } priv_state_t;

endpackage

`default_nettype wire

// ==== design/priv_unit_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module priv_unit_top (
    input  wire logic                  clk,
    input  wire logic                  rstn,
    // issue side
    input  wire logic                  en,
    input  wire priv_pkg::word_t       ins,
    input  wire priv_pkg::word_t       rd_data,
    input  wire priv_pkg::word_t       rj_data,
    input  wire priv_pkg::priv_class_t pr_type,
    output logic                       done,
    output priv_pkg::word_t            rd_result,
    // cache side
    output priv_pkg::cacop_code_t      cacop_code,
    output priv_pkg::word_t            cacop_vaddr,
    output logic                       cacop_i_req,
    output logic                       cacop_d_req,
    input  wire logic                  cacop_i_ready,
    input  wire logic                  cacop_d_ready,
    input  wire logic                  cacop_i_done,
    input  wire logic                  cacop_d_done,
    // exception return
    output logic                       ertn_en,
    output priv_pkg::word_t            ertn_pc,
    // status
    output logic [1:0]                 plv,
    output logic                       ie
);

    csr_if csr_bus ();

    priv_exec u_exec (
        .clk           (clk),
        .rstn          (rstn),
        .en            (en),
        .ins           (ins),
        .rd_data       (rd_data),
        .rj_data       (rj_data),
        .pr_type       (pr_type),
        .cacop_i_ready (cacop_i_ready),
        .cacop_d_ready (cacop_d_ready),
        .cacop_i_done  (cacop_i_done),
        .cacop_d_done  (cacop_d_done),
        .done          (done),
        .rd_result     (rd_result),
        .cacop_vaddr   (cacop_vaddr),
        .cacop_code    (cacop_code),
        .cacop_i_req   (cacop_i_req),
        .cacop_d_req   (cacop_d_req),
        .ertn_en       (ertn_en),
        .csr           (csr_bus.exec)
    );

    csr_file u_csr_file (
        .clk  (clk),
        .rstn (rstn),
        .csr  (csr_bus.file),
        .plv  (plv),
        .ie   (ie)
    );

    assign ertn_pc = csr_bus.ertn_era;  // return address straight from ERA

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the Verilator model of priv_tb and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f vlog.f --top-module priv_tb -o priv_sim \
    && ./obj_dir/priv_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
    && echo "simulation run ok" \
    || { echo "simulation run not ok"; exit 1; }

// ==== sim/priv_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "priv_cfg.svh"

module priv_tb;
    import priv_pkg::*;

    typedef enum logic [2:0] {K_NONE, K_CSR, K_ICACHE, K_DCACHE, K_NOP, K_ERTN} op_kind_t;

    typedef struct packed {
        op_kind_t    kind;
        csr_num_t    num;
        logic        wr;
        word_t       old_val;
        word_t       new_val;
        word_t       vaddr;
        cacop_code_t code;
        word_t       ret_pc;
        logic [2:0]  restore;  // pplv and pie going into crmd
    } expect_t;

    localparam priv_class_t CLS_CSR   = 3'b001 << `PRIV_CLS_CSR;
    localparam priv_class_t CLS_CACHE = 3'b001 << `PRIV_CLS_CACHE;
    localparam priv_class_t CLS_ERTN  = 3'b001 << `PRIV_CLS_ERTN;
    localparam word_t       ERTN_INS  = 32'h0648_3800;

    logic        clk;
    logic        rstn;
    logic        en;
    word_t       ins;
    word_t       rd_data;
    word_t       rj_data;
    priv_class_t pr_type;
    logic        done;
    word_t       rd_result;
    cacop_code_t cacop_code;
    word_t       cacop_vaddr;
    logic        cacop_i_req;
    logic        cacop_d_req;
    logic        cacop_i_ready;
    logic        cacop_d_ready;
    logic        cacop_i_done;
    logic        cacop_d_done;
    logic        ertn_en;
    word_t       ertn_pc;
    logic [1:0]  plv;
    logic        ie;

    integer   seed = 80;
    int       issued = 0;
    int       retired = 0;
    word_t    m_crmd;
    word_t    m_prmd;
    word_t    m_era;
    word_t    m_save [0:3];
    csr_num_t csr_list [0:8] = '{`CSR_CRMD, `CSR_PRMD, `CSR_ERA, `CSR_SAVE0,
        `CSR_SAVE0 + 14'd1, `CSR_SAVE0 + 14'd2, `CSR_SAVE0 + 14'd3, 14'h7, 14'h34};

    priv_unit_top i_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    function automatic word_t rand_word();
        return word_t'($random(seed));
    endfunction

    function automatic word_t csr_ins(input csr_num_t num, input logic [4:0] rj_idx);
        return {8'h04, num, rj_idx, 5'd4};
    endfunction

    function automatic word_t cacop_ins(input logic [11:0] off, input cacop_code_t code,
                                        input logic [2:0] tgt);
        return {10'h018, off, 5'd7, code, tgt};
    endfunction

    function automatic word_t mirror_read(input csr_num_t num);
        case (num)
            `CSR_CRMD:          return m_crmd;
            `CSR_PRMD:          return m_prmd;
            `CSR_ERA:           return m_era;
            `CSR_SAVE0:         return m_save[0];
            `CSR_SAVE0 + 14'd1: return m_save[1];
            `CSR_SAVE0 + 14'd2: return m_save[2];
            `CSR_SAVE0 + 14'd3: return m_save[3];
            default:            return '0;
        endcase
    endfunction

    function automatic void mirror_write(input csr_num_t num, input word_t val);
        case (num)
            `CSR_CRMD:          m_crmd = val & 32'h0000_000f;  // plv, ie, da
            `CSR_PRMD:          m_prmd = val & 32'h0000_0007;  // pplv, pie
            `CSR_ERA:           m_era = val;
            `CSR_SAVE0:         m_save[0] = val;
            `CSR_SAVE0 + 14'd1: m_save[1] = val;
            `CSR_SAVE0 + 14'd2: m_save[2] = val;
            `CSR_SAVE0 + 14'd3: m_save[3] = val;
            default:            ;
        endcase
    endfunction

    // expected outcome of one issued instruction against the mirror
    function automatic expect_t predict(input word_t ins_w, input priv_class_t cls,
                                        input word_t rd_w, input word_t mask_w);
        expect_t     e;
        logic [4:0]  rj_idx;
        logic [11:0] off;
        e      = '0;
        rj_idx = ins_w[9:5];
        off    = ins_w[21:10];
        e.kind = K_NONE;
        if (cls[`PRIV_CLS_CSR])
        begin
            e.kind    = K_CSR;
            e.num     = ins_w[23:10];
            e.old_val = mirror_read(e.num);
            e.wr      = rj_idx != 5'd0;
            e.new_val = (rj_idx == 5'd1) ? rd_w : ((e.old_val & ~mask_w) | (rd_w & mask_w));
        end
        else if (cls[`PRIV_CLS_CACHE])
        begin
            e.code  = ins_w[4:3];
            e.vaddr = mask_w + {{20{off[11]}}, off};
            case (ins_w[2:0])
                3'd0:    e.kind = K_ICACHE;
                3'd1:    e.kind = K_DCACHE;
                default: e.kind = K_NOP;
            endcase
        end
        else if (cls[`PRIV_CLS_ERTN])
        begin
            e.kind    = K_ERTN;
            e.ret_pc  = m_era;
            e.restore = m_prmd[2:0];
        end
        return e;
    endfunction

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_word(input string name, input word_t exp_v, input word_t act_v);
        if (act_v !== exp_v)
        begin
            $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic check_code(input string name, input cacop_code_t exp_v,
                              input cacop_code_t act_v);
        if (act_v !== exp_v)
        begin
            $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v)
        begin
            $display("[ERROR] %0t ns %s expected %b actual %b", $time, name, exp_v, act_v);
            abort_run();
        end
    endtask

    // called 1 ns after a rising edge, returns likewise once the DUT is idle again
    task automatic issue(input word_t ins_w, input priv_class_t cls, input word_t rd_w,
                         input word_t mask_w);
        ins     = ins_w;
        pr_type = cls;
        rd_data = rd_w;
        rj_data = mask_w;
        en      = 1'b1;
        if (cls != '0)
            issued++;
        @(posedge clk);
        #1;
        en = 1'b0;
        wait (retired == issued);
        @(posedge clk);
        #1;
    endtask

    task automatic drive_cache(input logic dside, input logic rdy, input logic dn);
        if (dside)
        begin
            cacop_d_ready = rdy;
            cacop_d_done  = dn;
        end
        else
        begin
            cacop_i_ready = rdy;
            cacop_i_done  = dn;
        end
    endtask

    task automatic serve_cache(input logic dside);
        int rdy_dly;
        int done_dly;
        drive_cache(dside, 1'b0, 1'b0);
        forever
        begin
            @(posedge clk);
            #1;
            if (rstn && (dside ? cacop_d_req : cacop_i_req))
            begin
                rdy_dly  = rand_below(6);
                done_dly = rand_below(8);
                repeat (rdy_dly)
                begin
                    @(posedge clk);
                    #1;
                end
                drive_cache(dside, 1'b1, done_dly == 0);  // done may share the ready cycle
                @(posedge clk);
                #1;
                drive_cache(dside, 1'b0, 1'b0);
                if (done_dly > 0)
                begin
                    repeat (done_dly - 1)
                    begin
                        @(posedge clk);
                        #1;
                    end
                    drive_cache(dside, 1'b0, 1'b1);
                    @(posedge clk);
                    #1;
                    drive_cache(dside, 1'b0, 1'b0);
                end
            end
        end
    endtask

    initial serve_cache(1'b0);
    initial serve_cache(1'b1);

    // samples mid cycle, inputs are held until done
    initial
    begin : compare
        expect_t exp_r;
        logic    active;
        logic    rdy_seen;
        logic    rdy_now;
        logic    dn_now;
        logic    rd_valid;
        word_t   last_rd;
        active   = 1'b0;
        rdy_seen = 1'b0;
        rd_valid = 1'b0;
        last_rd  = '0;
        exp_r    = '0;
        m_crmd   = `CRMD_RESET;
        m_prmd   = '0;
        m_era    = '0;
        for (int i = 0; i < 4; i++)
            m_save[i] = '0;
        forever
        begin
            @(negedge clk);
            if (rstn)
            begin
                check_bit("plv[1]", m_crmd[1], plv[1]);
                check_bit("plv[0]", m_crmd[0], plv[0]);
                check_bit("ie", m_crmd[2], ie);
                if (!active)
                begin
                    check_bit("done", 1'b0, done);
                    check_bit("cacop_i_req", 1'b0, cacop_i_req);
                    check_bit("cacop_d_req", 1'b0, cacop_d_req);
                    check_bit("ertn_en", 1'b0, ertn_en);
                    if (rd_valid)
                        check_word("rd_result", last_rd, rd_result);
                    if (en && pr_type != '0)
                    begin
                        exp_r    = predict(ins, pr_type, rd_data, rj_data);
                        active   = 1'b1;
                        rdy_seen = 1'b0;
                    end
                end
                else if (exp_r.kind == K_ICACHE || exp_r.kind == K_DCACHE)
                begin
                    rdy_now = (exp_r.kind == K_ICACHE) ? cacop_i_ready : cacop_d_ready;
                    dn_now  = (exp_r.kind == K_ICACHE) ? cacop_i_done : cacop_d_done;
                    check_code("cacop_code", exp_r.code, cacop_code);
                    check_word("cacop_vaddr", exp_r.vaddr, cacop_vaddr);
                    check_bit("cacop_i_req", exp_r.kind == K_ICACHE && !rdy_seen, cacop_i_req);
                    check_bit("cacop_d_req", exp_r.kind == K_DCACHE && !rdy_seen, cacop_d_req);
                    check_bit("ertn_en", 1'b0, ertn_en);
                    rdy_seen = rdy_seen | rdy_now;
                    check_bit("done", rdy_seen & dn_now, done);
                    active = !(rdy_seen & dn_now);
                end
                else
                begin
                    // csr, cacop no-op and ertn all end in cycle 1
                    check_bit("done", 1'b1, done);
                    check_bit("cacop_i_req", 1'b0, cacop_i_req);
                    check_bit("cacop_d_req", 1'b0, cacop_d_req);
                    check_bit("ertn_en", exp_r.kind == K_ERTN, ertn_en);
                    if (exp_r.kind == K_CSR)
                    begin
                        check_word("rd_result", exp_r.old_val, rd_result);
                        if (exp_r.wr)
                            mirror_write(exp_r.num, exp_r.new_val);
                        last_rd  = exp_r.old_val;
                        rd_valid = 1'b1;
                    end
                    if (exp_r.kind == K_ERTN)
                    begin
                        check_word("ertn_pc", exp_r.ret_pc, ertn_pc);
                        m_crmd[2:0] = exp_r.restore;
                    end
                    active = 1'b0;
                end
                if (!active && retired != issued)
                    retired++;
            end
        end
    end

    initial
    begin : watchdog
        #(400 * 20 * 8);
        $display("watchdog expired, the DUT stopped completing instructions");
        abort_run();
    end

    initial
    begin : stimulus
        word_t val;
        int    pick;
        rstn    = 1'b0;
        en      = 1'b0;
        ins     = '0;
        rd_data = '0;
        rj_data = '0;
        pr_type = '0;
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        check_bit("plv[1]", 1'b0, plv[1]);
        check_bit("plv[0]", 1'b0, plv[0]);
        check_bit("ie", 1'b0, ie);
        check_bit("done", 1'b0, done);
        check_bit("cacop_i_req", 1'b0, cacop_i_req);
        check_bit("cacop_d_req", 1'b0, cacop_d_req);
        check_bit("ertn_en", 1'b0, ertn_en);
        issue(csr_ins(`CSR_CRMD, 5'd0), CLS_CSR, '0, '0);
        check_word("rd_result", `CRMD_RESET, rd_result);

        foreach (csr_list[i])
        begin
            issue(csr_ins(csr_list[i], 5'd1), CLS_CSR, rand_word(), '0);  // csrwr
            issue(csr_ins(csr_list[i], 5'd0), CLS_CSR, '0, '0);
            issue(csr_ins(csr_list[i], 5'd9), CLS_CSR, rand_word(), rand_word());  // csrxchg
            issue(csr_ins(csr_list[i], 5'd0), CLS_CSR, '0, '0);
        end

        repeat (24)
            issue(cacop_ins(12'(rand_word()), 2'(rand_below(4)), 3'(rand_below(2))),
                  CLS_CACHE, '0, rand_word());
        for (int t = 2; t < 8; t++)
            issue(cacop_ins(12'(rand_word()), 2'(t), 3'(t)), CLS_CACHE, '0, rand_word());

        repeat (4)
        begin
            val = rand_word();
            issue(csr_ins(`CSR_PRMD, 5'd1), CLS_CSR, val, '0);
            issue(csr_ins(`CSR_ERA, 5'd1), CLS_CSR, rand_word(), '0);
            issue(ERTN_INS, CLS_ERTN, '0, '0);
            check_bit("plv[1]", val[1], plv[1]);
            check_bit("plv[0]", val[0], plv[0]);
            check_bit("ie", val[2], ie);
        end

        repeat (400)
        begin
            pick = rand_below(10);
            if (pick < 4)
                issue(csr_ins(csr_list[rand_below(9)], 5'(rand_below(3))), CLS_CSR,
                      rand_word(), rand_word());
            else if (pick < 8)
                issue(cacop_ins(12'(rand_word()), 2'(rand_below(4)), 3'(rand_below(3))),
                      CLS_CACHE, '0, rand_word());
            else if (pick < 9)
                issue(ERTN_INS, CLS_ERTN, '0, '0);
            else
                issue(rand_word(), '0, rand_word(), rand_word());  // no class bit, ignored
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+design
design/priv_pkg.sv
design/csr_if.sv
design/csr_file.sv
design/priv_exec.sv
design/priv_unit_top.sv
sim/priv_tb.sv
